//--- vlog.f
+incdir+src
src/dcu_bus_pkg.sv
src/dcu_mem_pkg.sv
src/dcu_port_regs.sv
src/rom_fetch_engine.sv
src/psram_reader.sv
src/inbuf_ring.sv
src/dcu_arbiter_top.sv
verification/tb_dcu_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DCU arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_dcu_arbiter -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    exit 1
fi
exit 0

//--- verification/tb_dcu_arbiter.sv
`timescale 1ns/1ps
`include "spc7110_macros.svh"

module tb_dcu_arbiter
    import dcu_bus_pkg::*;
    import dcu_mem_pkg::*;
();

    localparam byte_addr_t DIR_BASE     = 24'h0F_0010;
    localparam int         MAX_POLLS    = 200;
    localparam int         FILL_TIMEOUT = 40000;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        sfc_enable;
    sfc_bus_t    bus;
    logic        sfc_rom_rd = 1'b0;
    logic [15:0] psram_data;
    logic [7:0]  sfc_data_out;
    logic [22:0] psram_addr;
    logic        darb_rom_rd;

    logic        rom_noise_on;
    logic [31:0] rng_state = 32'hbda2_991b;
    int          darb_high_cycles = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;

    always #20 CLK = ~CLK;

    dcu_arbiter_top dut0 (
        .CLK          (CLK),
        .RESET        (RESET),
        .sfc_enable   (sfc_enable),
        .bus          (bus),
        .sfc_rom_rd   (sfc_rom_rd),
        .psram_data   (psram_data),
        .sfc_data_out (sfc_data_out),
        .psram_addr   (psram_addr),
        .darb_rom_rd  (darb_rom_rd)
    );

    ////////////////////////////////////////
    // Data ROM model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Stream pointer held in each of the 16 directory entries
    function automatic byte_addr_t entry_pointer(input logic [3:0] idx);
        case (idx)
            4'd3:    return 24'h12_3457;
            4'd9:    return 24'h40_FF00;
            4'd12:   return 24'h7E_FC01;
            default: return {4'h2, idx, 16'h0400};
        endcase
    endfunction

    function automatic logic [7:0] rom_byte(input byte_addr_t a);
        byte_addr_t rel;
        byte_addr_t ptr;
        rel = a - DIR_BASE;
        ptr = entry_pointer(rel[5:2]);
        if (a >= DIR_BASE && a < DIR_BASE + 24'd64) begin
            // Byte 0 is the mode byte, then the pointer high byte first
            case (rel[1:0])
                2'd0:    return 8'h00;
                2'd1:    return ptr[23:16];
                2'd2:    return ptr[15:8];
                default: return ptr[7:0];
            endcase
        end
        // Fill byte mixes all three address bytes
        return a[7:0] ^ a[15:8] ^ a[23:16];
    endfunction

    // Odd byte in the high half of each word
    assign psram_data = {rom_byte({psram_addr, 1'b1}), rom_byte({psram_addr, 1'b0})};

    // CPU ROM traffic on about one cycle in eight
    always @(posedge CLK) begin
        if (rom_noise_on) begin
            rng_state  <= xorshift32(rng_state);
            sfc_rom_rd <= (rng_state[2:0] == 3'd0);
        end else begin
            sfc_rom_rd <= 1'b0;
        end
        if (darb_rom_rd) begin
            darb_high_cycles <= darb_high_cycles + 1;
        end
    end

    ////////////////////////////////////////
    // CPU port access
    ////////////////////////////////////////

    task automatic cpu_write(input logic [3:0] port, input logic [7:0] data);
        @(posedge CLK);
        bus.port <= port;
        bus.data <= data;
        bus.wr   <= 1'b1;
        @(posedge CLK);
        bus.wr <= 1'b0;
    endtask

    task automatic cpu_read(input logic [3:0] port, output logic [7:0] data);
        @(posedge CLK);
        bus.port <= port;
        bus.rd   <= 1'b1;
        @(posedge CLK);
        bus.rd <= 1'b0;
        // Data register loaded on the edge that saw rd rise
        @(negedge CLK);
        data = sfc_data_out;
    endtask

    task automatic wait_data_ready(input string name, output bit ok);
        int         polls;
        logic [7:0] status;
        ok = 1'b0;
        for (polls = 0; polls < MAX_POLLS; polls++) begin
            cpu_read(`DCU_PORT_STATUS, status);
            if (status == `DCU_STATUS_READY) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout in %s: STATUS never reported data waiting", name);
            failure_count++;
        end
    endtask

    // Waits until the reader has been idle long enough for the ring to be full
    task automatic wait_ring_idle(input string name, output bit ok);
        int cycles;
        int quiet;
        ok = 1'b0;
        quiet = 0;
        for (cycles = 0; cycles < FILL_TIMEOUT; cycles++) begin
            @(negedge CLK);
            if (darb_rom_rd) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (quiet >= 64) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout in %s: PSRAM reads never stopped for a full ring", name);
            failure_count++;
        end
    endtask

    task automatic read_stream(input string name, input byte_addr_t first,
                               input int count, output bit ok);
        byte_addr_t addr;
        logic [7:0] got;
        logic [7:0] expected;
        int         k;
        addr = first;
        ok = 1'b1;
        for (k = 0; k < count; k++) begin
            wait_data_ready(name, ok);
            if (!ok) begin
                return;
            end
            cpu_read(`DCU_PORT_READ, got);
            expected = rom_byte(addr);
            if (got !== expected) begin
                $display("FAIL %s: byte %0d at %06h expected %02h, actual %02h",
                         name, k, addr, expected, got);
                mismatch_count++;
                ok = 1'b0;
                return;
            end
            addr = addr + 24'd1;
        end
    endtask

    task automatic check_length(input string name, input logic [15:0] expected);
        logic [7:0] lo;
        logic [7:0] hi;
        cpu_read(`DCU_PORT_COUNTER0, lo);
        cpu_read(`DCU_PORT_COUNTER1, hi);
        if ({hi, lo} !== expected) begin
            $display("FAIL %s: expected %04h, actual %04h", name, expected, {hi, lo});
            mismatch_count++;
        end
    endtask

    task automatic start_run(input logic [7:0] index, input logic [15:0] len);
        cpu_write(`DCU_PORT_INDEX, index);
        cpu_write(`DCU_PORT_COUNTER0, len[7:0]);
        cpu_write(`DCU_PORT_COUNTER1, len[15:8]);
        cpu_write(`DCU_PORT_OFFSET0, 8'h00);
        cpu_write(`DCU_PORT_OFFSET1, 8'h00);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_register_access();
        logic [3:0] ports [8];
        logic [7:0] values [8];
        logic [7:0] got;
        int         i;
        ports  = '{`DCU_PORT_BASE0, `DCU_PORT_BASE1, `DCU_PORT_BASE2, `DCU_PORT_INDEX,
                   `DCU_PORT_OFFSET0, `DCU_PORT_COUNTER0, `DCU_PORT_COUNTER1,
                   `DCU_PORT_OFFSET1};
        values = '{DIR_BASE[7:0], DIR_BASE[15:8], DIR_BASE[23:16], 8'h03,
                   8'hA5, 8'h21, 8'h03, 8'h5A};
        cpu_read(`DCU_PORT_STATUS, got);
        if (got !== `DCU_STATUS_EMPTY) begin
            $display("FAIL reset_status: expected %02h, actual %02h", `DCU_STATUS_EMPTY, got);
            mismatch_count++;
        end
        // OFFSET1 goes last so the counter bytes are live when read back
        for (i = 0; i < 8; i++) begin
            cpu_write(ports[i], values[i]);
        end
        for (i = 0; i < 8; i++) begin
            cpu_read(ports[i], got);
            if (got !== values[i]) begin
                $display("FAIL register_access port %h: expected %02h, actual %02h",
                         ports[i], values[i], got);
                mismatch_count++;
            end
        end
    endtask

    task automatic test_stream_start();
        bit ok;
        start_run(8'd3, 16'h0100);
        read_stream("stream_start", entry_pointer(4'd3), 40, ok);
        if (ok) begin
            check_length("length_count", 16'h0100 - 16'd40);
        end
    endtask

    task automatic test_rom_contention();
        bit ok;
        int darb_before;
        darb_before = darb_high_cycles;
        rom_noise_on <= 1'b1;
        start_run(8'd9, 16'h0080);
        read_stream("rom_contention", entry_pointer(4'd9), 64, ok);
        rom_noise_on <= 1'b0;
        if (darb_high_cycles == darb_before) begin
            $display("darb_rom_rd was never seen high during ROM contention");
            failure_count++;
        end
    endtask

    task automatic test_ring_wrap();
        bit ok;
        start_run(8'd12, 16'h0600);
        wait_ring_idle("ring_wrap", ok);
        if (!ok) begin
            return;
        end
        read_stream("ring_wrap", entry_pointer(4'd12), 1500, ok);
        if (ok) begin
            check_length("ring_wrap_length", 16'h0600 - 16'd1500);
        end
    endtask

    task automatic test_restart();
        bit ok;
        start_run(8'd3, 16'h0200);
        read_stream("restart_first", entry_pointer(4'd3), 20, ok);
        if (!ok) begin
            return;
        end
        start_run(8'd9, 16'h0200);
        read_stream("restart_second", entry_pointer(4'd9), 30, ok);
        if (ok) begin
            check_length("restart_length", 16'h0200 - 16'd30);
        end
    endtask

    initial begin
        RESET        = 1'b1;
        sfc_enable   = 1'b1;
        bus          = '0;
        rom_noise_on = 1'b0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        test_register_access();
        test_stream_start();
        test_rom_contention();
        test_ring_wrap();
        test_restart();

        $display("Summary: %0d value mismatches, %0d timeouts or other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src/dcu_arbiter_top.sv
`timescale 1ns/1ps

module dcu_arbiter_top
    import dcu_bus_pkg::*;
    import dcu_mem_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        sfc_enable,
    input  sfc_bus_t    bus,
    input  logic        sfc_rom_rd,
    input  logic [15:0] psram_data,
    output logic [7:0]  sfc_data_out,
    output logic [22:0] psram_addr,
    output logic        darb_rom_rd
);

    dcu_cfg_t   cfg;
    logic       start;
    logic       ring_pop;
    logic [7:0] ring_byte;
    logic       ring_empty;
    logic       ring_full;
    psram_req_t psram_req;
    psram_rsp_t psram_rsp;
    ring_wr_t   ring_wr;

    // CPU side
    dcu_port_regs u_port_regs (
        .CLK          (CLK),
        .RESET        (RESET),
        .bus          (bus),
        .sfc_enable   (sfc_enable),
        .ring_byte    (ring_byte),
        .ring_empty   (ring_empty),
        .sfc_data_out (sfc_data_out),
        .cfg          (cfg),
        .start        (start),
        .ring_pop     (ring_pop)
    );

    // Directory lookup and prefetch
    rom_fetch_engine u_fetch (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg       (cfg),
        .start     (start),
        .rsp       (psram_rsp),
        .ring_full (ring_full),
        .req       (psram_req),
        .ring_wr   (ring_wr)
    );

    psram_reader u_reader (
        .CLK         (CLK),
        .RESET       (RESET),
        .req         (psram_req),
        .sfc_rom_rd  (sfc_rom_rd),
        .psram_data  (psram_data),
        .rsp         (psram_rsp),
        .psram_addr  (psram_addr),
        .darb_rom_rd (darb_rom_rd)
    );

    inbuf_ring u_ring (
        .CLK   (CLK),
        .RESET (RESET),
        .flush (start),
        .wr    (ring_wr),
        .pop   (ring_pop),
        .head  (ring_byte),
        .empty (ring_empty),
        .full  (ring_full)
    );

endmodule

//--- src/inbuf_ring.sv
`timescale 1ns/1ps
`include "spc7110_macros.svh"

module inbuf_ring
    import dcu_mem_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       flush,
    input  ring_wr_t   wr,
    input  logic       pop,
    output logic [7:0] head,
    output logic       empty,
    output logic       full
);

    localparam int DEPTH = 1 << `DCU_RING_BITS;

    logic [7:0]                mem [0:DEPTH-1];
    logic [`DCU_RING_BITS-1:0] wr_ptr;
    logic [`DCU_RING_BITS-1:0] rd_ptr;
    logic [`DCU_RING_BITS-1:0] wr_next;

    assign wr_next = wr_ptr + 1'b1;
    assign head    = mem[rd_ptr];
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_next == rd_ptr);

    always_ff @(posedge CLK) begin
        if (wr.we && !full) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.we && !full) begin
                wr_ptr <= wr_next;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- src/psram_reader.sv
`timescale 1ns/1ps
`include "spc7110_macros.svh"

module psram_reader
    import dcu_mem_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  psram_req_t  req,
    input  logic        sfc_rom_rd,
    input  logic [15:0] psram_data,
    output psram_rsp_t  rsp,
    output logic [22:0] psram_addr,
    output logic        darb_rom_rd
);

    logic [3:0]  ctr;
    logic        busy;
    logic [22:0] addr_q;

    assign psram_addr  = addr_q;
    assign darb_rom_rd = (ctr != 4'd0);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ctr    <= '0;
            busy   <= 1'b0;
            addr_q <= '0;
            rsp    <= '0;
        end else begin
            if (!busy && !rsp.ack && req.req) begin
                busy   <= 1'b1;
                addr_q <= req.addr;
                ctr    <= `DCU_PSRAM_WAIT;
            end else if (busy && ctr != 4'd0) begin
                if (sfc_rom_rd) begin
                    // CPU took the bus, settle time starts over
                    ctr <= `DCU_PSRAM_WAIT;
                end else begin
                    ctr <= ctr - 4'd1;
                    if (ctr == 4'd1) begin
                        rsp.data <= psram_data;
                    end
                end
            end else if (busy) begin
                rsp.ack <= 1'b1;
                busy    <= 1'b0;
            end else if (rsp.ack && !req.req) begin
                rsp.ack <= 1'b0;
            end
        end
    end

endmodule

//--- src/rom_fetch_engine.sv
`timescale 1ns/1ps

module rom_fetch_engine
    import dcu_bus_pkg::*;
    import dcu_mem_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  dcu_cfg_t   cfg,
    input  logic       start,
    input  psram_rsp_t rsp,
    input  logic       ring_full,
    output psram_req_t req,
    output ring_wr_t   ring_wr
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PTR1,
        ST_PTR2,
        ST_PTR3,
        ST_STREAM
    } fetch_state_t;

    fetch_state_t state;
    byte_addr_t   cur_ptr;
    byte_addr_t   entry_addr;
    logic [15:0]  ptr_hi;
    logic         restart_pend;
    logic [7:0]   sel_byte;
    logic         issue_ok;

    // Entries are four bytes, the pointer starts at entry byte 1
    assign entry_addr = cfg.dir_base + {14'd0, cfg.dir_index, 2'b00} + 24'd1;

    // Odd byte addresses live in the high half of the word
    assign sel_byte = cur_ptr[0] ? rsp.data[15:8] : rsp.data[7:0];

    assign issue_ok = (state == ST_PTR1) || (state == ST_PTR2) || (state == ST_PTR3)
                   || ((state == ST_STREAM) && !ring_full);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= ST_IDLE;
            cur_ptr      <= '0;
            ptr_hi       <= '0;
            restart_pend <= 1'b0;
            req          <= '0;
            ring_wr      <= '0;
        end else begin
            ring_wr.we <= 1'b0;
            if (req.req && rsp.ack) begin
                // Transaction done, drop req and use or discard the data
                req.req <= 1'b0;
                if (start || restart_pend) begin
                    restart_pend <= 1'b0;
                    cur_ptr      <= entry_addr;
                    state        <= ST_PTR1;
                end else begin
                    case (state)
                        ST_PTR1: begin
                            ptr_hi[15:8] <= sel_byte;
                            cur_ptr      <= cur_ptr + 24'd1;
                            state        <= ST_PTR2;
                        end
                        ST_PTR2: begin
                            ptr_hi[7:0] <= sel_byte;
                            cur_ptr     <= cur_ptr + 24'd1;
                            state       <= ST_PTR3;
                        end
                        ST_PTR3: begin
                            cur_ptr <= {ptr_hi, sel_byte};
                            state   <= ST_STREAM;
                        end
                        ST_STREAM: begin
                            ring_wr.we   <= 1'b1;
                            ring_wr.data <= sel_byte;
                            cur_ptr      <= cur_ptr + 24'd1;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
            end else if (start) begin
                // Outstanding request has to finish before the restart
                if (req.req) begin
                    restart_pend <= 1'b1;
                end else begin
                    cur_ptr <= entry_addr;
                    state   <= ST_PTR1;
                end
            end else if (!req.req && !rsp.ack && issue_ok) begin
                req.req  <= 1'b1;
                req.addr <= cur_ptr[23:1];
            end
        end
    end

endmodule

//--- src/dcu_port_regs.sv
`timescale 1ns/1ps
`include "spc7110_macros.svh"

module dcu_port_regs
    import dcu_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  sfc_bus_t   bus,
    input  logic       sfc_enable,
    input  logic [7:0] ring_byte,
    input  logic       ring_empty,
    output logic [7:0] sfc_data_out,
    output dcu_cfg_t   cfg,
    output logic       start,
    output logic       ring_pop
);

    logic [23:0] dir_base;
    logic [7:0]  dir_index;
    logic [15:0] offset;
    logic [15:0] length_shadow;
    logic [15:0] length;
    logic        rd_last;
    logic        wr_last;
    logic        rd_hit;
    logic        wr_hit;

    // One access per rising edge of rd or wr
    assign rd_hit = bus.rd & ~rd_last & sfc_enable;
    assign wr_hit = bus.wr & ~wr_last & sfc_enable;

    // Head byte leaves the ring in the same cycle it is latched for the CPU
    assign ring_pop = rd_hit && (bus.port == `DCU_PORT_READ) && !ring_empty;

    assign cfg.dir_base  = dir_base;
    assign cfg.dir_index = dir_index;

    ////////////////////////////////////////
    // Port writes
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            rd_last       <= 1'b0;
            wr_last       <= 1'b0;
            dir_base      <= '0;
            dir_index     <= '0;
            offset        <= '0;
            length_shadow <= '0;
            length        <= '0;
            start         <= 1'b0;
        end else begin
            rd_last <= bus.rd;
            wr_last <= bus.wr;
            start   <= 1'b0;
            if (wr_hit) begin
                case (bus.port)
                    `DCU_PORT_BASE0:    dir_base[7:0]       <= bus.data;
                    `DCU_PORT_BASE1:    dir_base[15:8]      <= bus.data;
                    `DCU_PORT_BASE2:    dir_base[23:16]     <= bus.data;
                    `DCU_PORT_INDEX:    dir_index           <= bus.data;
                    `DCU_PORT_OFFSET0:  offset[7:0]         <= bus.data;
                    `DCU_PORT_COUNTER0: length_shadow[7:0]  <= bus.data;
                    `DCU_PORT_COUNTER1: length_shadow[15:8] <= bus.data;
                    `DCU_PORT_OFFSET1: begin
                        // High offset byte kicks off a new run
                        offset[15:8] <= bus.data;
                        length       <= length_shadow;
                        start        <= 1'b1;
                    end
                    default: ;
                endcase
            end else if (ring_pop) begin
                length <= length - 16'd1;
            end
        end
    end

    ////////////////////////////////////////
    // Port reads
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            sfc_data_out <= '0;
        end else if (rd_hit) begin
            case (bus.port)
                `DCU_PORT_READ:     sfc_data_out <= ring_empty ? 8'h00 : ring_byte;
                `DCU_PORT_BASE0:    sfc_data_out <= dir_base[7:0];
                `DCU_PORT_BASE1:    sfc_data_out <= dir_base[15:8];
                `DCU_PORT_BASE2:    sfc_data_out <= dir_base[23:16];
                `DCU_PORT_INDEX:    sfc_data_out <= dir_index;
                `DCU_PORT_OFFSET0:  sfc_data_out <= offset[7:0];
                `DCU_PORT_OFFSET1:  sfc_data_out <= offset[15:8];
                `DCU_PORT_COUNTER0: sfc_data_out <= length[7:0];
                `DCU_PORT_COUNTER1: sfc_data_out <= length[15:8];
                `DCU_PORT_STATUS: begin
                    sfc_data_out <= ring_empty ? `DCU_STATUS_EMPTY : `DCU_STATUS_READY;
                end
                default:            sfc_data_out <= 8'h00;
            endcase
        end
    end

endmodule

//--- src/dcu_mem_pkg.sv
package dcu_mem_pkg;

    // Byte address into the data ROM
    typedef logic [23:0] byte_addr_t;

    // Requester side of the PSRAM handshake
    typedef struct packed {
        logic        req;
        logic [22:0] addr;
    } psram_req_t;

    // Responder side, data held while ack is high
    typedef struct packed {
        logic        ack;
        logic [15:0] data;
    } psram_rsp_t;

    // One byte into the input ring
    typedef struct packed {
        logic       we;
        logic [7:0] data;
    } ring_wr_t;

endpackage

//--- src/dcu_bus_pkg.sv
package dcu_bus_pkg;

    // One CPU access to the DCU port window
    typedef struct packed {
        logic [3:0] port;
        logic       rd;
        logic       wr;
        logic [7:0] data;
    } sfc_bus_t;

    // Directory location of the entry to stream
    typedef struct packed {
        logic [23:0] dir_base;
        logic [7:0]  dir_index;
    } dcu_cfg_t;

endpackage

//--- src/spc7110_macros.svh
`ifndef SPC7110_MACROS_SVH
`define SPC7110_MACROS_SVH

////////////////////////////////////////
// CPU port numbers in the $4800 window
////////////////////////////////////////

`define DCU_PORT_READ       4'h0
`define DCU_PORT_BASE0      4'h1
`define DCU_PORT_BASE1      4'h2
`define DCU_PORT_BASE2      4'h3
`define DCU_PORT_INDEX      4'h4
`define DCU_PORT_OFFSET0    4'h5
`define DCU_PORT_OFFSET1    4'h6
`define DCU_PORT_COUNTER0   4'h9
`define DCU_PORT_COUNTER1   4'hA
`define DCU_PORT_STATUS     4'hC

////////////////////////////////////////
// Data ROM and ring sizing
////////////////////////////////////////

// PSRAM needs about 70 ns of settle time
`define DCU_PSRAM_WAIT      4'd7

// 1024 entries with one kept free to tell full from empty
`define DCU_RING_BITS       10

////////////////////////////////////////
// STATUS port codes
////////////////////////////////////////

`define DCU_STATUS_READY    8'h80
`define DCU_STATUS_EMPTY    8'h00

`endif
